// File: rtl/lr_core_cfg.svh
`ifndef LR_CORE_CFG_SVH
`define LR_CORE_CFG_SVH

// width of the data bus and of every 8-bit register.
`define LR_DATA_W 8

// width of the address bus, of the PC and of HL.
`define LR_ADDR_W 16

// the first opcode is fetched from this address after reset.
`define LR_RESET_PC 16'h0000

// clocks per machine cycle. The phase counter wraps after this many clocks.
`define LR_MCYCLE_LEN 4

`endif

// File: rtl/lr_core_pkg.sv
`default_nettype none

package lr_core_pkg;

	// machine state. It tells which bus access the current machine cycle makes.
	typedef enum logic [2:0] {
		st_ifetch,     // opcode read at PC.
		st_imml_fetch, // low immediate byte read at PC.
		st_immh_fetch, // high immediate byte read at PC.
		st_ind_fetch,  // data read at HL into the immediate latch.
		st_ind_store,  // data write at HL.
		st_jump        // no bus access; the relative jump is taken.
	} mstate_t;

	// the first eight codes follow opcode bits 5:3 of the ALU group.
	typedef enum logic [3:0] {
		alu_add, alu_adc, alu_sub, alu_sbc,
		alu_and, alu_xor, alu_or,  alu_cp,
		alu_inc, alu_dec, alu_pass
	} alu_op_t;

	// register select, coded like the 3-bit register fields of the opcode.
	typedef enum logic [2:0] {
		reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_mem, reg_a
	} reg_sel_t;

	typedef struct packed {
		logic z;  // result was zero.
		logic n;  // last operation subtracted.
		logic hc; // carry or borrow out of bit 3.
		logic cy; // carry or borrow out of bit 7.
	} flags_t;

	// one machine cycle is these four clocks in order.
	typedef enum logic [1:0] {ph_addr, ph_strobe, ph_latch, ph_end} bus_phase_t;

	typedef struct packed {
		alu_op_t  alu_op;
		reg_sel_t src_sel;     // reg_mem picks the immediate latch.
		reg_sel_t dst_sel;
		logic     reg_we;      // write the result to dst_sel in ph_end.
		logic     flags_we;    // write the ALU flags in ph_end.
		mstate_t  next_state;
		logic     adr_hl;      // next machine cycle addresses HL instead of the PC.
		logic     store;       // result goes to dout for the following store cycle.
		logic     pc_inc;      // PC steps past the byte fetched in this cycle.
		logic     pc_load_abs; // PC takes the 16-bit immediate.
		logic     pc_load_rel; // PC takes the relative target.
	} uop_t;

endpackage

`default_nettype wire

// File: rtl/lr_bus_sequencer.sv
`include "lr_core_cfg.svh"
`default_nettype none

module lr_bus_sequencer
	import lr_core_pkg::*;
(
	input  wire                  clk,
	input  wire                  reset,
	input  wire [`LR_DATA_W-1:0] data,
	input  wire [`LR_ADDR_W-1:0] pc,
	input  wire [`LR_ADDR_W-1:0] hl,
	input  wire uop_t            uop,
	input  wire [`LR_DATA_W-1:0] result,
	output logic [`LR_ADDR_W-1:0] adr,
	output logic [`LR_DATA_W-1:0] dout,
	output logic                 ddrv,
	output logic                 read,
	output logic                 write,
	output logic [`LR_DATA_W-1:0] op,
	output logic [`LR_DATA_W-1:0] imml,
	output logic [`LR_DATA_W-1:0] immh,
	output mstate_t              state,
	output bus_phase_t           phase
);

	localparam bus_phase_t last_phase = bus_phase_t'(`LR_MCYCLE_LEN - 1);

	logic hl_sel; // the decoder asked for HL as the address of this machine cycle.
	logic is_read;
	logic is_store;

	assign is_read  = state inside {st_ifetch, st_imml_fetch, st_immh_fetch, st_ind_fetch};
	assign is_store = state == st_ind_store;

	// the strobes are registered, so each one is decided one phase ahead of the clock it covers.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase  <= ph_addr;
			state  <= st_ifetch;
			hl_sel <= 1'b0;
			ddrv   <= 1'b0;
			read   <= 1'b0;
			write  <= 1'b0;
		end
		else
		begin
			phase <= (phase == last_phase) ? ph_addr : bus_phase_t'(phase + 2'd1);
			case (phase)
				ph_addr:   ddrv  <= is_store; // only a store drives the data bus.
				ph_strobe:
				begin
					read  <= is_read;
					write <= is_store; // high for ph_latch only.
				end
				ph_latch:  write <= 1'b0;
				ph_end:
				begin
					read   <= 1'b0;
					state  <= uop.next_state;
					hl_sel <= uop.adr_hl;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (phase == ph_addr)
			adr <= hl_sel ? hl : pc; // held for the rest of the machine cycle.
		// data is sampled on the clock that ends ph_latch.
		if (phase == ph_latch)
		begin
			case (state)
				st_ifetch:                   op   <= data;
				st_imml_fetch, st_ind_fetch: imml <= data; // a byte read at HL shares the latch.
				st_immh_fetch:               immh <= data;
				default:                     op   <= op;
			endcase
		end
		if (phase == ph_end && uop.store)
			dout <= result; // stays stable through the store cycle that follows.
	end

endmodule

`default_nettype wire

// File: rtl/lr_decode.sv
`default_nettype none

module lr_decode
	import lr_core_pkg::*;
(
	input  wire [7:0]    op,
	input  wire mstate_t state,
	input  wire flags_t  flags,
	output uop_t         uop
);

	reg_sel_t op_dst; // register field in bits 5:3.
	reg_sel_t op_src; // register field in bits 2:0.
	logic     fetching;
	logic     jr_taken;

	assign op_dst   = reg_sel_t'(op[5:3]);
	assign op_src   = reg_sel_t'(op[2:0]);
	assign fetching = state inside {st_ifetch, st_imml_fetch, st_immh_fetch};

	// JR 18 always jumps. Bit 4 picks cy over z and bit 3 gives the level that jumps.
	assign jr_taken = (op == 8'h18) || ((op[4] ? flags.cy : flags.z) == op[3]);

	always_comb
	begin
		uop            = '0;
		uop.alu_op     = alu_pass;
		uop.src_sel    = op_src;
		uop.dst_sel    = op_dst;
		uop.next_state = st_ifetch; // most instructions end after this machine cycle.
		uop.pc_inc     = fetching;

		casez (op)
			8'h00: uop.next_state = st_ifetch; // NOP.
			8'h18, 8'b001?_?000: // JR and JR cc.
				case (state)
					st_ifetch:     uop.next_state = st_imml_fetch;
					st_imml_fetch: uop.next_state = jr_taken ? st_jump : st_ifetch;
					st_jump:       uop.pc_load_rel = 1'b1;
					default:       uop.next_state = st_ifetch;
				endcase
			8'b00??_?110: // LD r,d8. The (HL) form is not kept.
				if (op_dst != reg_mem)
				begin
					if (state == st_ifetch)
						uop.next_state = st_imml_fetch;
					else
					begin
						uop.src_sel = reg_mem;
						uop.reg_we  = 1'b1;
					end
				end
			8'b00??_?10?: // INC r and DEC r in a single machine cycle.
				if (op_dst != reg_mem)
				begin
					uop.alu_op   = op[0] ? alu_dec : alu_inc;
					uop.src_sel  = op_dst;
					uop.reg_we   = 1'b1;
					uop.flags_we = 1'b1;
				end
			8'b01??_????: // LD r,r'. Code 76 is HALT and stays a NOP.
				if (op != 8'h76)
				begin
					if (op_src == reg_mem && state == st_ifetch)
					begin
						uop.next_state = st_ind_fetch; // the byte at HL arrives in imml.
						uop.adr_hl     = 1'b1;
					end
					else if (op_dst == reg_mem)
					begin
						if (state == st_ifetch)
						begin
							uop.store      = 1'b1;
							uop.adr_hl     = 1'b1;
							uop.next_state = st_ind_store;
						end
					end
					else
						uop.reg_we = 1'b1;
				end
			8'b10??_????, 8'b11??_?110: // ALU on A with a register, (HL) or d8.
			begin
				uop.alu_op = alu_op_t'({1'b0, op[5:3]});
				if (state == st_ifetch && op_src == reg_mem)
				begin
					uop.next_state = op[6] ? st_imml_fetch : st_ind_fetch;
					uop.adr_hl     = !op[6];
				end
				else
				begin
					uop.dst_sel  = reg_a;
					uop.reg_we   = op[5:3] != 3'd7; // CP only sets the flags.
					uop.flags_we = 1'b1;
				end
			end
			8'hc3: // JP a16. The PC loads once both bytes are in.
				case (state)
					st_ifetch:     uop.next_state = st_imml_fetch;
					st_imml_fetch: uop.next_state = st_immh_fetch;
					st_immh_fetch: uop.pc_load_abs = 1'b1;
					default:       uop.next_state = st_ifetch;
				endcase
			default: uop.next_state = st_ifetch; // anything else runs as a NOP.
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/lr_alu.sv
`include "lr_core_cfg.svh"
`default_nettype none

module lr_alu
	import lr_core_pkg::*;
(
	input  wire uop_t             uop,
	input  wire [`LR_DATA_W-1:0]  a,
	input  wire [`LR_DATA_W-1:0]  operand,
	input  wire flags_t           flags,
	input  wire [`LR_ADDR_W-1:0]  pc,
	input  wire [`LR_DATA_W-1:0]  imml,
	output logic [`LR_DATA_W-1:0] result,
	output flags_t                flags_out,
	output logic [`LR_ADDR_W-1:0] target
);

	logic [`LR_DATA_W-1:0] lhs;
	logic [`LR_DATA_W-1:0] rhs;
	logic                  cin;
	logic                  sub;
	logic                  step;  // INC or DEC.
	logic                  bitop; // AND, XOR or OR.
	logic [`LR_DATA_W:0]   wide;  // bit 8 is the carry or borrow out.
	logic [4:0]            half;  // low nibble with its carry out in bit 4.

	assign step  = uop.alu_op inside {alu_inc, alu_dec};
	assign bitop = uop.alu_op inside {alu_and, alu_xor, alu_or};
	assign sub   = uop.alu_op inside {alu_sub, alu_sbc, alu_cp, alu_dec};
	assign cin   = (uop.alu_op inside {alu_adc, alu_sbc}) ? flags.cy : 1'b0;
	assign lhs   = step ? operand : a; // INC and DEC act on the source register.
	assign rhs   = step ? `LR_DATA_W'(1) : operand;

	assign wide = sub ? {1'b0, lhs} - {1'b0, rhs} - {8'd0, cin}
	                  : {1'b0, lhs} + {1'b0, rhs} + {8'd0, cin};
	assign half = sub ? {1'b0, lhs[3:0]} - {1'b0, rhs[3:0]} - {4'd0, cin}
	                  : {1'b0, lhs[3:0]} + {1'b0, rhs[3:0]} + {4'd0, cin};

	always_comb
	begin
		case (uop.alu_op)
			alu_and:  result = a & operand;
			alu_xor:  result = a ^ operand;
			alu_or:   result = a | operand;
			alu_pass: result = operand; // plain register and memory moves.
			default:  result = wide[`LR_DATA_W-1:0];
		endcase
		flags_out.z  = result == '0;
		flags_out.n  = sub;
		flags_out.hc = (uop.alu_op == alu_and) || (!bitop && half[4]);
		flags_out.cy = step ? flags.cy : (!bitop && wide[`LR_DATA_W]); // INC and DEC keep cy.
	end

	// JR offset is signed and counts from the byte after the instruction.
	assign target = pc + {{(`LR_ADDR_W - `LR_DATA_W){imml[`LR_DATA_W-1]}}, imml};

endmodule

`default_nettype wire

// File: rtl/lr_regfile.sv
`include "lr_core_cfg.svh"
`default_nettype none

module lr_regfile
	import lr_core_pkg::*;
(
	input  wire                   clk,
	input  wire                   reset,
	input  wire uop_t             uop,
	input  wire bus_phase_t       phase,
	input  wire [`LR_DATA_W-1:0]  result,
	input  wire flags_t           flags_in,
	input  wire [`LR_ADDR_W-1:0]  target,
	input  wire [`LR_DATA_W-1:0]  imml,
	input  wire [`LR_DATA_W-1:0]  immh,
	output logic [`LR_DATA_W-1:0] operand,
	output logic [`LR_DATA_W-1:0] a,
	output logic [`LR_ADDR_W-1:0] hl,
	output logic [`LR_ADDR_W-1:0] pc,
	output flags_t                flags
);

	// indexed by reg_sel_t. Slot 6 is never written since that code means memory or immediate.
	logic [`LR_DATA_W-1:0] rf [8];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc    <= `LR_RESET_PC;
			flags <= '0;
		end
		else if (phase == ph_strobe && uop.pc_inc)
			pc <= pc + `LR_ADDR_W'(1); // step past the byte being read.
		else if (phase == ph_end)
		begin
			if (uop.pc_load_abs)
				pc <= {immh, imml};
			else if (uop.pc_load_rel)
				pc <= target;
			if (uop.flags_we)
				flags <= flags_in;
		end
	end

	// results land at the end of the machine cycle, together with the state change.
	always_ff @(posedge clk)
	begin
		if (phase == ph_end && uop.reg_we)
			rf[uop.dst_sel] <= result;
	end

	assign operand = (uop.src_sel == reg_mem) ? imml : rf[uop.src_sel];
	assign a       = rf[reg_a];
	assign hl      = {rf[reg_h], rf[reg_l]};

endmodule

`default_nettype wire

// File: rtl/lr_core.sv
`include "lr_core_cfg.svh"
`default_nettype none

module lr_core
	import lr_core_pkg::*;
(
	input  wire                   clk,
	input  wire                   reset,
	output logic [`LR_ADDR_W-1:0] adr,
	input  wire [`LR_DATA_W-1:0]  data,
	output logic [`LR_DATA_W-1:0] dout,
	output logic                  ddrv,
	output logic                  read,
	output logic                  write
);

	logic [`LR_DATA_W-1:0] op, imml, immh, result, operand, a;
	logic [`LR_ADDR_W-1:0] pc, hl, target;
	mstate_t               state;
	bus_phase_t            phase;
	uop_t                  uop;
	flags_t                flags, alu_flags;

	// the sequencer owns the bus and the machine state. The other three work on its latches.
	lr_bus_sequencer u_seq (.clk, .reset, .data, .pc, .hl, .uop, .result, .adr, .dout,
		.ddrv, .read, .write, .op, .imml, .immh, .state, .phase);

	lr_decode u_decode (.op, .state, .flags, .uop);

	lr_alu u_alu (.uop, .a, .operand, .flags, .pc, .imml, .result,
		.flags_out(alu_flags), .target);

	lr_regfile u_regfile (.clk, .reset, .uop, .phase, .result, .flags_in(alu_flags),
		.target, .imml, .immh, .operand, .a, .hl, .pc, .flags);

endmodule

`default_nettype wire

// File: testbench/lr_clock_gen.sv
`default_nettype none

module lr_clock_gen #(
	parameter int period       = 4, // clock period in ns.
	parameter int reset_cycles = 5  // rising edges that see reset high.
) (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0; // released on a falling edge like every other DUT input.
	end

endmodule

`default_nettype wire

// File: testbench/lr_core_assert.sv
`default_nettype none

module lr_core_assert (
	input wire clk,
	input wire reset,
	input wire read,
	input wire write,
	input wire ddrv
);
	timeunit 1ns;
	timeprecision 100ps;

	int overlap_fails = 0;
	int drive_fails   = 0;
	int pulse_fails   = 0;
	int failures;           // all protocol violations seen so far.

	assign failures = overlap_fails + drive_fails + pulse_fails;

	// a machine cycle either reads or writes, never both.
	no_overlap: assert property (@(posedge clk) disable iff (reset) !(read && write))
	else
	begin
		$error("read and write are high in the same clock");
		overlap_fails++;
	end

	// the core owns the data bus for the whole write strobe.
	write_drives: assert property (@(posedge clk) disable iff (reset) write |-> ddrv)
	else
	begin
		$error("write is high while ddrv is low");
		drive_fails++;
	end

	write_pulse: assert property (@(posedge clk) disable iff (reset) write |=> !write)
	else
	begin
		$error("write stayed high for more than one clock");
		pulse_fails++;
	end

endmodule

bind lr_core lr_core_assert u_assert (.clk, .reset, .read, .write, .ddrv);

`default_nettype wire

// File: testbench/lr_core_tb.sv
`include "lr_core_cfg.svh"
`default_nettype none

module lr_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int list_base = 'hf000; // expected writes start here in the image.
	localparam int margin    = 200;    // reset and slack on top of the program length.

	// one expected bus write, laid out as four bytes of the data file.
	typedef struct packed {
		logic [7:0]            test;
		logic [`LR_ADDR_W-1:0] adr;
		logic [`LR_DATA_W-1:0] data;
	} write_entry_t;

	logic                  clk;
	logic                  reset;
	logic [`LR_ADDR_W-1:0] adr;
	logic [`LR_DATA_W-1:0] data;
	logic [`LR_DATA_W-1:0] dout;
	logic                  ddrv;
	logic                  read;
	logic                  write;

	logic [`LR_DATA_W-1:0] mem [65536]; // the whole 64 KiB address space.
	write_entry_t          expected [$];
	logic [`LR_ADDR_W-1:0] end_adr;      // address of the closing JR -2.
	int                    next_exp     = 0;
	int                    checks       = 0;
	int                    value_errors = 0;
	int                    other_errors = 0;
	int                    cycles       = 0;
	int                    cycle_limit  = 0;

	lr_clock_gen #(.period(4), .reset_cycles(5)) u_clock_gen (.clk, .reset);

	lr_core u_lr_core (.clk, .reset, .adr, .data, .dout, .ddrv, .read, .write);

	function automatic string test_name(input logic [7:0] idx);
		case (idx)
			8'd1:    return "reset_ld_imm";
			8'd2:    return "ld_reg_and_mem";
			8'd3:    return "alu_ops";
			8'd4:    return "inc_dec_carry";
			8'd5:    return "jumps";
			default: return "unknown";
		endcase
	endfunction

	// compares one bus write with the next entry of the list.
	task automatic check_write();
		write_entry_t want;
		checks++;
		assert (next_exp < expected.size())
		else
		begin
			other_errors++;
			$display("unexpected write of %h to %h after the last expected write", dout, adr);
		end
		if (next_exp < expected.size())
		begin
			want = expected[next_exp];
			next_exp++;
			assert (adr == want.adr && dout == want.data)
			else
			begin
				value_errors++;
				$display("FAILED %s: expected %h at %h, actual %h at %h",
					test_name(want.test), want.data, want.adr, dout, adr);
			end
		end
	endtask

	task automatic finish_run();
		int protocol_errors;
		protocol_errors = u_lr_core.u_assert.failures;
		assert (next_exp == expected.size())
		else
		begin
			other_errors++;
			$display("only %0d of %0d expected writes were seen", next_exp, expected.size());
		end
		$display("writes checked %0d, value errors %0d, other errors %0d, protocol errors %0d",
			checks, value_errors, other_errors, protocol_errors);
		if (value_errors + other_errors + protocol_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	// memory model. It loads the image, then serves reads and takes writes on falling edges.
	initial
	begin
		int pos;
		data = '0;
		$readmemh("testbench/lr_core_tests.mem", mem);
		pos = list_base;
		while (pos < 65532 && mem[pos] != 8'hff)
		begin
			expected.push_back({mem[pos], mem[pos + 1], mem[pos + 2], mem[pos + 3]});
			pos += 4;
		end
		end_adr     = {mem[pos + 1], mem[pos + 2]};
		// three machine cycles per program byte is the slowest any instruction runs.
		cycle_limit = (int'(end_adr) + 2) * 3 * `LR_MCYCLE_LEN + margin;
		assert (expected.size() > 0)
		else
		begin
			other_errors++;
			$display("the data file holds no expected writes");
		end
		forever
		begin
			@(negedge clk);
			if (write)
				mem[adr] = dout; // adr and dout are settled half a clock into the strobe.
			data <= mem[adr];
		end
	end

	// bus writes are checked on the falling edge, halfway through the write strobe.
	always @(negedge clk)
	begin
		if (!reset && write)
			check_write();
		if (!reset && read && adr == end_adr)
			finish_run(); // the program reached its closing loop.
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			other_errors++;
			$display("timeout after %0d cycles without reaching the loop at %h", cycles, end_adr);
			finish_run();
		end
	end

endmodule

`default_nettype wire

// File: testbench/lr_core_tests.mem
// program bytes from 0000 and the byte at 9001 that LD D,(HL) reads back.
// expected writes from F000, four bytes each: test, address high, address low, byte.
// the entry with test FF gives the address of the closing JR -2.
@0000
26 80 2E 00 06 A5 70                    // 1: HL=8000, B=A5, store B.
48 2E 01 71 26 90 56 26 80 2E 02 72     // 2: C=B, store C, D=(9001), store D.
2E 03 3E 3C 80 77                       // 3: ADD A,B.
C6 30 77 CE 00 77 D6 13 77 DE 0F 77     // 3: ADD, ADC, SUB, SBC immediate.
E6 5A 77 EE FF 77 F6 0A 77              // 3: AND, XOR, OR immediate.
BA 77 96 77                             // 3: CP D, SUB (HL).
1E FF 3E FF 83 1C 73                    // 4: set cy, INC E wraps to 00.
3E 00 8B 77 1D 73 8B 77                 // 4: ADC shows cy, DEC E wraps, ADC again.
3E 5A 28 01 77 20 01 77                 // 5: z=1, JR Z skips, JR NZ falls through.
38 01 77 30 01 70                       // 5: cy=1, JR C skips, JR NC falls through.
B7 20 01 77 30 01 77 28 01 72 38 01 77  // 5: OR A clears z and cy.
18 01 77 C3 63 00 77                    // 5: JR and JP over a store.
18 03 73 18 02 18 FB                    // 5: backward JR onto a store.
18 FE                                   // closing loop.
@9001
3C
@F000
01 80 00 A5
02 80 01 A5  02 80 02 3C
03 80 03 E1  03 80 03 11  03 80 03 12  03 80 03 FF  03 80 03 EF
03 80 03 4A  03 80 03 B5  03 80 03 BF  03 80 03 BF  03 80 03 00
04 80 03 00  04 80 03 01  04 80 03 FF  04 80 03 00
05 80 03 5A  05 80 03 A5  05 80 03 3C  05 80 03 5A  05 80 03 FF
FF 00 6A 00

// File: project.f
+incdir+rtl
rtl/lr_core_pkg.sv
rtl/lr_bus_sequencer.sv
rtl/lr_decode.sv
rtl/lr_alu.sv
rtl/lr_regfile.sv
rtl/lr_core.sv
testbench/lr_clock_gen.sv
testbench/lr_core_assert.sv
testbench/lr_core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module lr_core_tb -o lr_core_sim &&
./obj_dir/lr_core_sim +verilator+error+limit+1000 | tee /dev/stderr | grep -q "Test passed" &&
echo "simulation ok" ||
{ echo "simulation not ok"; exit 1; }
